// File: id_remap_pkg.sv
package id_remap_pkg;

    // ------------------------------------------------------------------
    // field widths
    // ------------------------------------------------------------------
    localparam int ORIG_ID_W = 4;                    // id as seen on the bus
    localparam int ROW_IDX_W = 2;                    // up to 4 rows
    localparam int COL_IDX_W = 2;                    // up to 4 columns per row
    localparam int UID_W     = ROW_IDX_W + COL_IDX_W; // row bits sit above column bits

    // ------------------------------------------------------------------
    // vector types
    // ------------------------------------------------------------------
    // original transaction id from the requester
    typedef logic [ORIG_ID_W-1:0] orig_id_t;

    typedef logic [ROW_IDX_W-1:0] row_idx_t;  // table row
    typedef logic [COL_IDX_W-1:0] col_idx_t;  // slot within a row

    // remapped id, {row, col}
    typedef logic [UID_W-1:0] uid_t;

    // one occupancy bit per column of a row
    typedef logic [(1 << COL_IDX_W)-1:0] col_mask_t;

    // outstanding slot count, has to reach 16 so one bit over UID_W
    typedef logic [UID_W:0] out_cnt_t;

endpackage

// File: row_binder.sv
`timescale 1ns/1ps

module row_binder #(
    parameter int NUM_ROWS = 4
) (
    input  logic                   clk,
    input  logic                   rst,
    input  id_remap_pkg::orig_id_t in_orig_id,
    input  logic                   alloc_gnt,
    input  logic                   row_release,
    input  id_remap_pkg::row_idx_t release_row,
    output logic                   choice_valid,
    output id_remap_pkg::row_idx_t chosen_row
);
    import id_remap_pkg::*;

    // ------------------------------------------------------------------
    // binding state
    // ------------------------------------------------------------------
    logic [NUM_ROWS-1:0] row_bound;          // row currently owned by an id
    orig_id_t            bound_id [NUM_ROWS]; // owner id, only meaningful when bound

    // search results
    logic [NUM_ROWS-1:0] row_hit;            // one-hot at most, an id owns a single row
    logic                have_hit;
    logic                have_unbound;
    row_idx_t            hit_row;
    row_idx_t            unbound_row;        // lowest row nobody owns
    logic                bind_now;           // grant into a row that was free

    // ------------------------------------------------------------------
    // hit search and row choice
    // ------------------------------------------------------------------
    always_comb begin
        hit_row     = '0;
        unbound_row = '0;
        // walk downwards so the lowest index is the last one written
        for (int r = NUM_ROWS - 1; r >= 0; r--) begin
            row_hit[r] = row_bound[r] && (bound_id[r] == in_orig_id);
            if (row_hit[r]) begin
                hit_row = row_idx_t'(r);
            end
            if (!row_bound[r]) begin
                unbound_row = row_idx_t'(r);
            end
        end
        have_hit     = |row_hit;
        have_unbound = ~&row_bound;          // at least one row still free
    end

    assign choice_valid = have_hit || have_unbound;
    assign chosen_row   = have_hit ? hit_row : unbound_row; // sharing wins over a new row
    assign bind_now     = alloc_gnt && !have_hit;

    // ------------------------------------------------------------------
    // bind / unbind
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            row_bound <= '0;
        end else begin
            for (int r = 0; r < NUM_ROWS; r++) begin
                // release and bind never target the same row, a bound
                // row is released and only an unbound row gets bound
                if (row_release && (release_row == row_idx_t'(r))) begin
                    row_bound[r] <= 1'b0;
                end
                if (bind_now && (chosen_row == row_idx_t'(r))) begin
                    row_bound[r] <= 1'b1;
                end
            end
        end
    end

    // owner id follows the bind strobe
    always_ff @(posedge clk) begin
        for (int r = 0; r < NUM_ROWS; r++) begin
            if (bind_now && (chosen_row == row_idx_t'(r))) begin
                bound_id[r] <= in_orig_id;
            end
        end
    end

endmodule

// File: slot_tracker.sv
`timescale 1ns/1ps

module slot_tracker #(
    parameter int NUM_ROWS = 4,
    parameter int NUM_COLS = 4
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   alloc_req,
    input  logic                   choice_valid,
    input  id_remap_pkg::row_idx_t chosen_row,
    input  logic                   free_req,
    input  id_remap_pkg::uid_t     free_uid,
    output logic                   alloc_gnt,
    output id_remap_pkg::uid_t     unique_id,
    output logic                   row_release,
    output id_remap_pkg::row_idx_t release_row,
    output logic                   id_table_full
);
    import id_remap_pkg::*;

    localparam int CAPACITY = NUM_ROWS * NUM_COLS; // total slots in the table

    // ------------------------------------------------------------------
    // occupancy state
    // ------------------------------------------------------------------
    col_mask_t row_mask [NUM_ROWS];      // set bit = slot is live
    col_mask_t row_mask_nxt [NUM_ROWS];
    out_cnt_t  total_cnt;                // live slots over the whole table

    col_mask_t cur_mask;                 // mask of the chosen row
    col_mask_t rel_mask;                 // next mask of the row being freed
    col_idx_t  free_col;                 // lowest clear column in cur_mask
    logic      col_avail;                // chosen row still has room

    row_idx_t  dealloc_row;
    col_idx_t  dealloc_col;

    // free uid split, row on top
    assign dealloc_row = free_uid[UID_W-1:COL_IDX_W];
    assign dealloc_col = free_uid[COL_IDX_W-1:0];

    // ------------------------------------------------------------------
    // column choice and grant
    // ------------------------------------------------------------------
    always_comb begin
        cur_mask = '0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            if (chosen_row == row_idx_t'(r)) begin
                cur_mask = row_mask[r];
            end
        end
        free_col  = '0;
        col_avail = 1'b0;
        for (int c = NUM_COLS - 1; c >= 0; c--) begin // lowest clear bit wins
            if (!cur_mask[c]) begin
                free_col  = col_idx_t'(c);
                col_avail = 1'b1;
            end
        end
    end

    // state from before the edge decides, a free this cycle does not help
    assign alloc_gnt = alloc_req && choice_valid && col_avail;
    assign unique_id = {chosen_row, free_col};

    // ------------------------------------------------------------------
    // mask update and release detect
    // ------------------------------------------------------------------
    always_comb begin
        rel_mask = '0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            row_mask_nxt[r] = row_mask[r];
            if (alloc_gnt && (chosen_row == row_idx_t'(r))) begin
                row_mask_nxt[r][free_col] = 1'b1;
            end
            if (free_req && (dealloc_row == row_idx_t'(r))) begin
                row_mask_nxt[r][dealloc_col] = 1'b0;
            end
            if (dealloc_row == row_idx_t'(r)) begin
                rel_mask = row_mask_nxt[r];
            end
        end
    end

    // row empties only if no grant refills it in the same cycle
    assign row_release = free_req && (rel_mask == '0);
    assign release_row = dealloc_row;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < NUM_ROWS; r++) begin
                row_mask[r] <= '0;
            end
            total_cnt <= '0;
        end else begin
            for (int r = 0; r < NUM_ROWS; r++) begin
                row_mask[r] <= row_mask_nxt[r];
            end
            // net change, alloc and free together leave it as is
            total_cnt <= total_cnt + out_cnt_t'(alloc_gnt) - out_cnt_t'(free_req);
        end
    end

    assign id_table_full = (total_cnt == out_cnt_t'(CAPACITY));

endmodule

// File: tag_store.sv
`timescale 1ns/1ps

module tag_store #(
    parameter int NUM_ROWS = 4,
    parameter int NUM_COLS = 4
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   alloc_gnt,
    input  id_remap_pkg::uid_t     unique_id,
    input  id_remap_pkg::orig_id_t in_orig_id,
    input  logic                   free_req,
    input  id_remap_pkg::uid_t     free_uid,
    output id_remap_pkg::orig_id_t restored_id,
    output logic                   free_ack
);
    import id_remap_pkg::*;

    orig_id_t tag_mem [NUM_ROWS][NUM_COLS]; // original id per live slot
    orig_id_t rd_tag;                       // tag addressed by free_uid

    // ------------------------------------------------------------------
    // tag write on grant
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        for (int r = 0; r < NUM_ROWS; r++) begin
            for (int c = 0; c < NUM_COLS; c++) begin
                if (alloc_gnt && (unique_id == uid_t'({row_idx_t'(r), col_idx_t'(c)}))) begin
                    tag_mem[r][c] <= in_orig_id;
                end
            end
        end
    end

    // read port, old contents even when a grant writes elsewhere this cycle
    always_comb begin
        rd_tag = '0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            for (int c = 0; c < NUM_COLS; c++) begin
                if (free_uid == uid_t'({row_idx_t'(r), col_idx_t'(c)})) begin
                    rd_tag = tag_mem[r][c];
                end
            end
        end
    end

    // registered free response, one cycle after free_req
    always_ff @(posedge clk) begin
        if (rst) begin
            free_ack    <= 1'b0;
            restored_id <= '0;
        end else begin
            free_ack    <= free_req;
            restored_id <= free_req ? rd_tag : '0; // zero when idle
        end
    end

endmodule

// File: id_remapper.sv
`timescale 1ns/1ps

module id_remapper #(
    parameter int NUM_ROWS = 4, // 1 to 4
    parameter int NUM_COLS = 4  // 1 to 4
) (
    input  logic                   clk,
    input  logic                   rst,
    // allocation side
    input  logic                   alloc_req,
    input  id_remap_pkg::orig_id_t in_orig_id,
    output logic                   alloc_gnt,
    output id_remap_pkg::uid_t     unique_id,
    output logic                   id_table_full,
    // free side
    input  logic                   free_req,
    input  id_remap_pkg::uid_t     free_uid,
    output id_remap_pkg::orig_id_t restored_id,
    output logic                   free_ack
);
    import id_remap_pkg::*;

    // ------------------------------------------------------------------
    // internal links
    // ------------------------------------------------------------------
    logic     choice_valid; // binder has a row for in_orig_id
    row_idx_t chosen_row;
    logic     row_release;  // last slot of a row freed
    row_idx_t release_row;

    // which row an id lives in
    row_binder #(
        .NUM_ROWS (NUM_ROWS)
    ) u_row_binder (
        .clk          (clk),
        .rst          (rst),
        .in_orig_id   (in_orig_id),
        .alloc_gnt    (alloc_gnt),
        .row_release  (row_release),
        .release_row  (release_row),
        .choice_valid (choice_valid),
        .chosen_row   (chosen_row)
    );

    // which columns are live, grant and fill level
    slot_tracker #(
        .NUM_ROWS (NUM_ROWS),
        .NUM_COLS (NUM_COLS)
    ) u_slot_tracker (
        .clk           (clk),
        .rst           (rst),
        .alloc_req     (alloc_req),
        .choice_valid  (choice_valid),
        .chosen_row    (chosen_row),
        .free_req      (free_req),
        .free_uid      (free_uid),
        .alloc_gnt     (alloc_gnt),
        .unique_id     (unique_id),
        .row_release   (row_release),
        .release_row   (release_row),
        .id_table_full (id_table_full)
    );

    // original id per slot, answers frees
    tag_store #(
        .NUM_ROWS (NUM_ROWS),
        .NUM_COLS (NUM_COLS)
    ) u_tag_store (
        .clk         (clk),
        .rst         (rst),
        .alloc_gnt   (alloc_gnt),
        .unique_id   (unique_id),
        .in_orig_id  (in_orig_id),
        .free_req    (free_req),
        .free_uid    (free_uid),
        .restored_id (restored_id),
        .free_ack    (free_ack)
    );

endmodule

// File: id_remapper_asserts.sv
`timescale 1ns/1ps

module id_remapper_asserts (
    input logic               clk,
    input logic               rst,
    input logic               alloc_gnt,
    input id_remap_pkg::uid_t unique_id,
    input logic               id_table_full,
    input logic               free_req,
    input id_remap_pkg::uid_t free_uid,
    input logic               free_ack
);
    import id_remap_pkg::*;

    logic [(1 << UID_W)-1:0] live;         // shadow occupancy with one bit per uid
    int                      fail_cnt = 0; // failed property checks

    always_ff @(posedge clk) begin
        if (rst) begin
            live <= '0;
        end else begin
            if (alloc_gnt) live[unique_id] <= 1'b1;
            if (free_req) live[free_uid] <= 1'b0; // never the slot granted this cycle
        end
    end

    // ------------------------------------------------------------------
    // protocol properties
    // ------------------------------------------------------------------
    ack_follows_free: assert property (@(posedge clk) disable iff (rst)
        free_ack == $past(free_req))
        else begin
            fail_cnt++;
            $error("free_ack is not free_req delayed by one cycle");
        end

    no_gnt_when_full: assert property (@(posedge clk) disable iff (rst)
        id_table_full |-> !alloc_gnt)
        else begin
            fail_cnt++;
            $error("alloc_gnt high while the table is full");
        end

    free_only_live: assert property (@(posedge clk) disable iff (rst)
        free_req |-> live[free_uid])
        else begin
            fail_cnt++;
            $error("free_req for a unique id that is not outstanding");
        end

endmodule

bind id_remapper id_remapper_asserts u_asserts (
    .clk           (clk),
    .rst           (rst),
    .alloc_gnt     (alloc_gnt),
    .unique_id     (unique_id),
    .id_table_full (id_table_full),
    .free_req      (free_req),
    .free_uid      (free_uid),
    .free_ack      (free_ack)
);

// File: id_remapper_tb.sv
`timescale 1ns/1ps

module id_remapper_tb;
    import id_remap_pkg::*;

    localparam int NUM_ROWS    = 4;
    localparam int NUM_COLS    = 4;
    localparam int RAND_CYCLES = 200;
    localparam int MAX_CYCLES  = RAND_CYCLES + 200; // directed tests take about 70 cycles

    logic     clk = 1'b0;
    logic     rst;
    logic     alloc_req;
    logic     free_req;
    logic     alloc_gnt;
    logic     id_table_full;
    logic     free_ack;
    orig_id_t in_orig_id;
    orig_id_t restored_id;
    uid_t     free_uid;
    uid_t     unique_id;

    // ------------------------------------------------------------------
    // reference model state
    // ------------------------------------------------------------------
    logic                m_bound [NUM_ROWS];  // row owned by an id
    orig_id_t            m_owner [NUM_ROWS];
    logic [NUM_COLS-1:0] m_mask [NUM_ROWS];   // live columns per row
    orig_id_t            m_tag [16];          // original id per uid
    int                  m_cnt;
    logic                ack_due;             // free seen last cycle
    orig_id_t            tag_due;
    logic                got_gnt;             // dut outputs of the last cycle
    uid_t                got_uid;
    int                  errors;
    logic [31:0]         seed;

    always #20 clk = ~clk; // 40 ns period

    id_remapper #(.NUM_ROWS(NUM_ROWS), .NUM_COLS(NUM_COLS)) dut (.*);

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_val(input string name, input logic [7:0] got, input logic [7:0] want);
        assert (got === want) else begin
            errors++;
            $display("** Error: %s = %h, expected %h at %0t", name, got, want, $time);
        end
    endtask

    // the owner row beats the lowest unbound row and the lowest clear column is taken
    function automatic logic predict_alloc(input orig_id_t id, output uid_t uid);
        int row;
        int col;
        row = -1;
        col = -1;
        uid = '0;
        for (int r = NUM_ROWS - 1; r >= 0; r--) begin
            if (!m_bound[r]) row = r;                  // ends on the lowest one
        end
        for (int r = 0; r < NUM_ROWS; r++) begin
            if (m_bound[r] && m_owner[r] == id) row = r; // sharing beats a new row
        end
        if (row < 0) return 1'b0;
        for (int c = NUM_COLS - 1; c >= 0; c--) begin
            if (!m_mask[row][c]) col = c;
        end
        uid = uid_t'((row << COL_IDX_W) + col);        // row bits on top
        return col >= 0;
    endfunction

    // first live uid from start onwards with wrap-around
    function automatic logic find_live(input int start, output uid_t uid);
        uid = '0;
        for (int k = 0; k < 16; k++) begin
            uid = uid_t'(start + k);
            if (m_mask[uid[UID_W-1:COL_IDX_W]][uid[COL_IDX_W-1:0]]) return 1'b1;
        end
        return 1'b0;
    endfunction

    // ------------------------------------------------------------------
    // one clock cycle that drives, checks at the falling edge and updates the model
    // ------------------------------------------------------------------
    task automatic run_cycle(input logic do_alloc, input orig_id_t id,
                             input logic do_free, input uid_t fuid);
        logic     can_gnt;
        logic     exp_gnt;
        uid_t     exp_uid;
        orig_id_t free_tag;
        int       row;
        alloc_req  = do_alloc;
        in_orig_id = id;
        free_req   = do_free;
        free_uid   = fuid;
        can_gnt    = predict_alloc(id, exp_uid); // state from before the edge
        exp_gnt    = do_alloc && can_gnt;
        free_tag   = m_tag[fuid];
        @(negedge clk);
        got_gnt = alloc_gnt;
        got_uid = unique_id;
        check_val("alloc_gnt", 8'(alloc_gnt), 8'(exp_gnt));
        if (exp_gnt) check_val("unique_id", 8'(unique_id), 8'(exp_uid));
        check_val("id_table_full", 8'(id_table_full), 8'(m_cnt == NUM_ROWS * NUM_COLS));
        check_val("free_ack", 8'(free_ack), 8'(ack_due));
        check_val("restored_id", 8'(restored_id), ack_due ? 8'(tag_due) : 8'h0);
        if (exp_gnt) begin
            row          = int'(exp_uid[UID_W-1:COL_IDX_W]);
            m_bound[row] = 1'b1;
            m_owner[row] = id;
            m_mask[row][exp_uid[COL_IDX_W-1:0]] = 1'b1;
            m_tag[exp_uid] = id;
        end
        if (do_free) begin
            row = int'(fuid[UID_W-1:COL_IDX_W]);
            m_mask[row][fuid[COL_IDX_W-1:0]] = 1'b0;
            if (m_mask[row] == '0) m_bound[row] = 1'b0; // row unbound once its last slot is gone
        end
        m_cnt   = m_cnt + int'(exp_gnt) - int'(do_free);
        ack_due = do_free;                            // response due next cycle
        tag_due = free_tag;
        @(posedge clk);
        #2;
    endtask

    task automatic free_all();
        uid_t uid;
        while (find_live(0, uid)) run_cycle(1'b0, '0, 1'b1, uid);
        run_cycle(1'b0, '0, 1'b0, '0);                 // picks up the last free_ack
    endtask

    // ------------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------------
    task automatic reset_defaults();
        run_cycle(1'b0, '0, 1'b0, '0);                 // flags idle after reset
        run_cycle(1'b1, 4'h5, 1'b0, '0);
        check_val("unique_id", 8'(got_uid), 8'h0);
        free_all();
    endtask

    task automatic same_id_sharing();
        for (int k = 0; k < 4; k++) begin
            run_cycle(1'b1, 4'h3, 1'b0, '0);
            check_val("unique_id", 8'(got_uid), 8'(k));
        end
        run_cycle(1'b1, 4'h3, 1'b0, '0);               // its row is full now
        check_val("alloc_gnt", 8'(got_gnt), 8'h0);
        free_all();
    endtask

    task automatic distinct_rows();
        for (int k = 0; k < 4; k++) begin
            run_cycle(1'b1, orig_id_t'(k + 1), 1'b0, '0);
            check_val("unique_id", 8'(got_uid), 8'(k * NUM_COLS));
        end
        for (int k = 0; k < 4; k++) begin
            run_cycle(1'b0, '0, 1'b1, uid_t'(k * NUM_COLS));
            check_val("free_ack", 8'(free_ack), 8'h1);  // registered so steady after the edge
            check_val("restored_id", 8'(restored_id), 8'(k + 1));
        end
        free_all();
    endtask

    task automatic fill_table();
        for (int k = 0; k < 16; k++) run_cycle(1'b1, orig_id_t'(6 + k / 4), 1'b0, '0);
        check_val("id_table_full", 8'(id_table_full), 8'h1);
        run_cycle(1'b1, 4'hA, 1'b0, '0);               // no row left for a new id
        check_val("alloc_gnt", 8'(got_gnt), 8'h0);
        run_cycle(1'b0, '0, 1'b1, 4'h5);
        check_val("id_table_full", 8'(id_table_full), 8'h0);
        free_all();
    endtask

    task automatic slot_reuse();
        for (int k = 0; k < 3; k++) run_cycle(1'b1, 4'h2, 1'b0, '0); // uids 0 to 2
        run_cycle(1'b1, 4'hB, 1'b0, '0);               // binds row 1
        run_cycle(1'b0, '0, 1'b1, 4'h1);               // middle column of row 0
        run_cycle(1'b1, 4'h2, 1'b0, '0);
        check_val("unique_id", 8'(got_uid), 8'h1);
        for (int k = 0; k < 3; k++) run_cycle(1'b0, '0, 1'b1, uid_t'(k));
        run_cycle(1'b1, 4'h9, 1'b0, '0);               // freed row 0 beats row 2
        check_val("unique_id", 8'(got_uid), 8'h0);
        free_all();
    endtask

    task automatic random_traffic();
        logic     pend;
        logic     found;
        orig_id_t id;
        uid_t     uid;
        pend = 1'b0;
        id   = '0;
        for (int n = 0; n < RAND_CYCLES; n++) begin
            seed = lcg_step(seed);
            if (!pend) begin                           // a refused request is held
                pend = seed[24];
                id   = orig_id_t'(seed[30:28]);        // 8 ids are enough to share rows
            end
            found = find_live(int'(seed[15:12]), uid);
            run_cycle(pend, id, found && seed[20], uid);
            if (got_gnt) pend = 1'b0;
        end
        free_all();
    endtask

    // ------------------------------------------------------------------
    // run and report
    // ------------------------------------------------------------------
    initial begin
        errors     = 0;
        seed       = 32'h540014af;
        rst        = 1'b1;
        alloc_req  = 1'b0;
        in_orig_id = '0;
        free_req   = 1'b0;
        free_uid   = '0;
        ack_due    = 1'b0;
        tag_due    = '0;
        m_cnt      = 0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            m_bound[r] = 1'b0;
            m_owner[r] = '0;
            m_mask[r]  = '0;
        end
        for (int i = 0; i < 16; i++) m_tag[i] = '0;
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;
        reset_defaults();
        same_id_sharing();
        distinct_rows();
        fill_table();
        slot_reuse();
        random_traffic();
        errors = errors + dut.u_asserts.fail_cnt; // bound protocol checks
        $display("error count: %0d", errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin
        repeat (MAX_CYCLES) @(posedge clk);
        $display("timeout: tests still running after %0d cycles", MAX_CYCLES);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

// File: all.f
id_remap_pkg.sv
row_binder.sv
slot_tracker.sv
tag_store.sv
id_remapper.sv
id_remapper_asserts.sv
id_remapper_tb.sv

// File: Bender.yml
package:
  name: id_remapper

sources:
  - id_remap_pkg.sv
  - row_binder.sv
  - slot_tracker.sv
  - tag_store.sv
  - id_remapper.sv
  - target: simulation
    files:
      - id_remapper_asserts.sv
      - id_remapper_tb.sv
